// File: list.f
src/axil_pkg.sv
src/rec_pkg.sv
src/flop_fifo.sv
src/channel_siderec.sv
src/rec_merge.sv
src/axil_recorder.sv
verif/clk_gen.sv
verif/axil_recorder_tb.sv

// File: Makefile
# Verilator build and run of the AXI-lite recorder testbench

VERILATOR ?= verilator
TOP       ?= axil_recorder_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

PASS_MSG  := *** TEST PASSED ***
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation binary
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run and decide on the pass message in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: verif/axil_recorder_tb.sv
`timescale 1ns/1ns

module axil_recorder_tb;

   localparam int DEPTH           = 8;
   localparam int ADDR_W          = axil_pkg::ADDR_W;
   localparam int DATA_W          = axil_pkg::DATA_W;
   localparam int STRB_W          = axil_pkg::STRB_W;
   localparam int RESP_W          = axil_pkg::RESP_W;
   localparam int AW_W            = axil_pkg::AW_REC_W;
   localparam int W_W             = axil_pkg::W_REC_W;
   localparam int AR_W            = axil_pkg::AR_REC_W;
   localparam int SEQ_W           = rec_pkg::SEQ_W;
   // three flag pairs plus the three payloads
   localparam int REC_W           = 3 * rec_pkg::REC_FLAG_W + AW_W + W_W + AR_W;
   localparam int RESET_CYCLES    = 5;
   localparam int RANDOM_CYCLES   = 400;
   localparam int DIRECTED_CYCLES = 20;
   localparam int DRAIN_CYCLES    = 4 * DEPTH;
   // four directed tests and the random run each with a drain and 2x margin
   localparam int TIMEOUT_CYCLES  =
      2 * (RESET_CYCLES + 4 * DIRECTED_CYCLES + RANDOM_CYCLES + 5 * DRAIN_CYCLES);

   logic                 clk;
   logic                 sync_rst_n;
   logic [ADDR_W-1:0]    sh_awaddr;
   logic                 sh_awvalid;
   logic                 sh_awready;
   logic [DATA_W-1:0]    sh_wdata;
   logic [STRB_W-1:0]    sh_wstrb;
   logic                 sh_wvalid;
   logic                 sh_wready;
   logic [ADDR_W-1:0]    sh_araddr;
   logic                 sh_arvalid;
   logic                 sh_arready;
   logic [RESP_W-1:0]    sh_bresp;
   logic                 sh_bvalid;
   logic                 sh_bready;
   logic [DATA_W-1:0]    sh_rdata;
   logic [RESP_W-1:0]    sh_rresp;
   logic                 sh_rvalid;
   logic                 sh_rready;
   logic [ADDR_W-1:0]    cl_awaddr;
   logic                 cl_awvalid;
   logic                 cl_awready;
   logic [DATA_W-1:0]    cl_wdata;
   logic [STRB_W-1:0]    cl_wstrb;
   logic                 cl_wvalid;
   logic                 cl_wready;
   logic [ADDR_W-1:0]    cl_araddr;
   logic                 cl_arvalid;
   logic                 cl_arready;
   logic [RESP_W-1:0]    cl_bresp;
   logic                 cl_bvalid;
   logic                 cl_bready;
   logic [DATA_W-1:0]    cl_rdata;
   logic [RESP_W-1:0]    cl_rresp;
   logic                 cl_rvalid;
   logic                 cl_rready;
   logic                 rec_valid;
   logic                 rec_ready;
   logic [SEQ_W-1:0]     rec_seq;
   logic                 rec_aw_ispkt;
   logic                 rec_aw_busy;
   logic [AW_W-1:0]      rec_aw_data;
   logic                 rec_w_ispkt;
   logic                 rec_w_busy;
   logic [W_W-1:0]       rec_w_data;
   logic                 rec_ar_ispkt;
   logic                 rec_ar_busy;
   logic [AR_W-1:0]      rec_ar_data;

   int                   seed;
   int                   errors;
   int                   records_seen;
   string                test_name;
   // hold back fresh requests while a watermark may be up
   logic                 guard_full;
   // model state in channel order aw w ar
   logic [2:0]           prev_busy;
   logic [2:0]           acc;
   logic [SEQ_W-1:0]     exp_seq;
   logic [REC_W-1:0]     exp_q[$];
   // entries held in each channel fifo and the output slot
   int                   fifo_cnt;
   logic                 out_full;

   clk_gen #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
      .clk        (clk),
      .sync_rst_n (sync_rst_n)
   );

   axil_recorder #(.DEPTH(DEPTH)) u_axil_recorder (.*);

   //////////////////////////////////////////////////
   // reference model and checks
   //////////////////////////////////////////////////

   // a channel is a packet on its first valid cycle and a bubble otherwise
   function automatic logic [REC_W-1:0] expect_record(
      input logic [2:0]      valid,
      input logic [2:0]      busy_before,
      input logic [AW_W-1:0] aw,
      input logic [W_W-1:0]  w,
      input logic [AR_W-1:0] ar
   );
      logic [2:0] pkt;
      pkt = valid & ~busy_before;
      return {pkt[2], busy_before[2], aw, pkt[1], busy_before[1], w,
              pkt[0], busy_before[0], ar};
   endfunction

   function automatic logic coin(input int one_in);
      return ($random(seed) % one_in) == 0;
   endfunction

   task automatic check_value(
      input string            name,
      input logic [REC_W-1:0] expected,
      input logic [REC_W-1:0] actual
   );
      assert (actual === expected) else begin
         errors++;
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   always @(posedge clk) begin : monitor
      logic [2:0]       vld;
      logic [2:0]       rdy;
      logic [REC_W-1:0] act_rec;
      logic             wm;
      logic             pushed;
      logic             load;
      if (sync_rst_n) begin
         // watermark at one slot short of full gates both sides
         wm = (fifo_cnt >= DEPTH - 1);
         check_value({test_name, " gating"},
                     REC_W'({sh_awvalid && !wm, sh_wvalid && !wm, sh_arvalid && !wm,
                             cl_awready && !wm, cl_wready && !wm, cl_arready && !wm}),
                     REC_W'({cl_awvalid, cl_wvalid, cl_arvalid,
                             sh_awready, sh_wready, sh_arready}));
         check_value({test_name, " rec_valid"}, REC_W'(out_full), REC_W'(rec_valid));
         // payloads and responses pass straight through
         check_value({test_name, " request path"},
                     REC_W'({sh_awaddr, sh_wdata, sh_wstrb, sh_araddr}),
                     REC_W'({cl_awaddr, cl_wdata, cl_wstrb, cl_araddr}));
         check_value({test_name, " response path"},
                     REC_W'({cl_bresp, cl_bvalid, sh_bready,
                             cl_rdata, cl_rresp, cl_rvalid, sh_rready}),
                     REC_W'({sh_bresp, sh_bvalid, cl_bready,
                             sh_rdata, sh_rresp, sh_rvalid, cl_rready}));
         // record beat against the head of the queue
         if (rec_valid && rec_ready) begin
            act_rec = {rec_aw_ispkt, rec_aw_busy, rec_aw_data, rec_w_ispkt, rec_w_busy,
                       rec_w_data, rec_ar_ispkt, rec_ar_busy, rec_ar_data};
            assert (exp_q.size() != 0) else begin
               errors++;
               $display("record with seq %0d arrived while none was expected", rec_seq);
            end
            if (exp_q.size() != 0)
               check_value(test_name, exp_q.pop_front(), act_rec);
            check_value({test_name, " seq"}, REC_W'(exp_seq), REC_W'(rec_seq));
            exp_seq = exp_seq + SEQ_W'(1);
            records_seen++;
         end
         // shell requests seen this cycle
         vld = {sh_awvalid, sh_wvalid, sh_arvalid};
         rdy = {sh_awready, sh_wready, sh_arready};
         pushed = ((vld & ~prev_busy) != 3'b000);
         if (pushed)
            exp_q.push_back(expect_record(vld, prev_busy, sh_awaddr,
                                          {sh_wdata, sh_wstrb}, sh_araddr));
         prev_busy = vld & ~rdy;
         acc       = vld & rdy;
         // output slot loads from the fifo heads when empty or draining
         load     = (fifo_cnt != 0) && (!out_full || rec_ready);
         out_full = load || (out_full && !rec_ready);
         fifo_cnt = fifo_cnt + int'(pushed) - int'(load);
      end
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   // one cycle of shell requests, client readies and record ready
   task automatic drive_cycle(
      input logic [2:0] start,
      input logic [2:0] cl_rdy,
      input logic       rec_rdy
   );
      logic       safe;
      logic [2:0] pend;
      logic [2:0] go;
      @(negedge clk);
      // watermark shows only on a channel whose client is ready
      safe = (cl_awready && sh_awready) || (cl_wready && sh_wready) ||
             (cl_arready && sh_arready);
      pend = {sh_awvalid, sh_wvalid, sh_arvalid} & ~acc;
      go   = (guard_full && !safe) ? 3'b000 : start;
      // a pending request keeps valid and payload
      if (!pend[2]) begin
         sh_awvalid = go[2];
         sh_awaddr  = ADDR_W'($random(seed));
      end
      if (!pend[1]) begin
         sh_wvalid = go[1];
         sh_wdata  = DATA_W'($random(seed));
         sh_wstrb  = STRB_W'($random(seed));
      end
      if (!pend[0]) begin
         sh_arvalid = go[0];
         sh_araddr  = ADDR_W'($random(seed));
      end
      // client responder
      {cl_awready, cl_wready, cl_arready} = cl_rdy;
      rec_ready = rec_rdy;
      // unrecorded b and r traffic
      cl_bresp  = RESP_W'($random(seed));
      cl_bvalid = coin(2);
      sh_bready = coin(2);
      cl_rdata  = DATA_W'($random(seed));
      cl_rresp  = RESP_W'($random(seed));
      cl_rvalid = coin(2);
      sh_rready = coin(2);
   endtask

   // idle until every request is taken and every record is out
   task automatic wait_drain();
      do begin
         drive_cycle(3'b000, 3'b111, 1'b1);
      end while (exp_q.size() != 0 || {sh_awvalid, sh_wvalid, sh_arvalid} != 3'b000);
      // a few more cycles to catch a stray record
      repeat (3) drive_cycle(3'b000, 3'b111, 1'b1);
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin : main
      int base;
      seed         = 19;
      errors       = 0;
      records_seen = 0;
      test_name    = "reset";
      guard_full   = 1'b0;
      prev_busy    = 3'b000;
      acc          = 3'b000;
      exp_seq      = '0;
      fifo_cnt     = 0;
      out_full     = 1'b0;
      sh_awaddr    = '0;
      sh_awvalid   = 1'b0;
      sh_wdata     = '0;
      sh_wstrb     = '0;
      sh_wvalid    = 1'b0;
      sh_araddr    = '0;
      sh_arvalid   = 1'b0;
      sh_bready    = 1'b1;
      sh_rready    = 1'b1;
      cl_awready   = 1'b1;
      cl_wready    = 1'b1;
      cl_arready   = 1'b1;
      cl_bresp     = '0;
      cl_bvalid    = 1'b0;
      cl_rdata     = '0;
      cl_rresp     = '0;
      cl_rvalid    = 1'b0;
      rec_ready    = 1'b1;
      wait (sync_rst_n === 1'b1);
      @(posedge clk);
      // output slot empty and sequence at zero
      check_value("reset", REC_W'(0), REC_W'({rec_valid, rec_seq}));

      // address and data of one write in the same cycle
      test_name = "single_write";
      base      = records_seen;
      drive_cycle(3'b110, 3'b111, 1'b1);
      wait_drain();
      check_value("single_write count", REC_W'(1), REC_W'(records_seen - base));

      test_name = "single_read";
      base      = records_seen;
      drive_cycle(3'b001, 3'b111, 1'b1);
      wait_drain();
      check_value("single_read count", REC_W'(1), REC_W'(records_seen - base));

      // aw held by the client while a read slips in
      test_name = "client_stall";
      base      = records_seen;
      for (int i = 0; i < 5; i++) begin
         drive_cycle((i == 0) ? 3'b100 : ((i == 2) ? 3'b001 : 3'b000), 3'b011, 1'b1);
         @(posedge clk);
         check_value("client_stall awready", REC_W'(cl_awready), REC_W'(sh_awready));
         check_value("client_stall awvalid", REC_W'(1), REC_W'(cl_awvalid));
      end
      wait_drain();
      check_value("client_stall count", REC_W'(2), REC_W'(records_seen - base));

      // reads back to back while the record stream is stalled
      test_name = "record_backpressure";
      base      = records_seen;
      repeat (DEPTH + 4) drive_cycle(3'b001, 3'b111, 1'b0);
      @(posedge clk);
      // counts are equal so every channel is held off
      check_value("record_backpressure arready", REC_W'(0), REC_W'(sh_arready));
      check_value("record_backpressure arvalid", REC_W'(0), REC_W'(cl_arvalid));
      check_value("record_backpressure awready", REC_W'(0), REC_W'(sh_awready));
      check_value("record_backpressure pending", REC_W'(1), REC_W'(sh_arvalid));
      wait_drain();
      check_value("record_backpressure count", REC_W'(DEPTH + 1),
                  REC_W'(records_seen - base));

      test_name  = "random_traffic";
      guard_full = 1'b1;
      repeat (RANDOM_CYCLES) begin
         drive_cycle({coin(4), coin(4), coin(4)}, {!coin(4), !coin(4), !coin(4)}, !coin(4));
      end
      guard_full = 1'b0;
      wait_drain();

      // last record carries one less than the number of records in the run
      test_name = "sequence";
      check_value("sequence last", REC_W'(records_seen - 1), REC_W'(rec_seq));

      $display("summary: %0d records checked, %0d errors", records_seen, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // cycle limit on the whole run
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles in %s, %0d records checked, %0d errors",
               cycles, test_name, records_seen, errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic sync_rst_n
);

   // free running clock
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // release on a falling edge, clear of the sampling edge
   initial begin
      sync_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;
   end

endmodule

// File: src/axil_recorder.sv
`timescale 1ns/1ns

module axil_recorder #(
   parameter int DEPTH = 8
) (
   input  logic                               clk,
   input  logic                               sync_rst_n,
   // shell side
   input  logic [axil_pkg::ADDR_W-1:0]        sh_awaddr,
   input  logic                               sh_awvalid,
   output logic                               sh_awready,
   input  logic [axil_pkg::DATA_W-1:0]        sh_wdata,
   input  logic [axil_pkg::STRB_W-1:0]        sh_wstrb,
   input  logic                               sh_wvalid,
   output logic                               sh_wready,
   input  logic [axil_pkg::ADDR_W-1:0]        sh_araddr,
   input  logic                               sh_arvalid,
   output logic                               sh_arready,
   output logic [axil_pkg::RESP_W-1:0]        sh_bresp,
   output logic                               sh_bvalid,
   input  logic                               sh_bready,
   output logic [axil_pkg::DATA_W-1:0]        sh_rdata,
   output logic [axil_pkg::RESP_W-1:0]        sh_rresp,
   output logic                               sh_rvalid,
   input  logic                               sh_rready,
   // client side
   output logic [axil_pkg::ADDR_W-1:0]        cl_awaddr,
   output logic                               cl_awvalid,
   input  logic                               cl_awready,
   output logic [axil_pkg::DATA_W-1:0]        cl_wdata,
   output logic [axil_pkg::STRB_W-1:0]        cl_wstrb,
   output logic                               cl_wvalid,
   input  logic                               cl_wready,
   output logic [axil_pkg::ADDR_W-1:0]        cl_araddr,
   output logic                               cl_arvalid,
   input  logic                               cl_arready,
   input  logic [axil_pkg::RESP_W-1:0]        cl_bresp,
   input  logic                               cl_bvalid,
   output logic                               cl_bready,
   input  logic [axil_pkg::DATA_W-1:0]        cl_rdata,
   input  logic [axil_pkg::RESP_W-1:0]        cl_rresp,
   input  logic                               cl_rvalid,
   output logic                               cl_rready,
   // record stream
   output logic                               rec_valid,
   input  logic                               rec_ready,
   output logic [rec_pkg::SEQ_W-1:0]          rec_seq,
   output logic                               rec_aw_ispkt,
   output logic                               rec_aw_busy,
   output logic [axil_pkg::AW_REC_W-1:0]      rec_aw_data,
   output logic                               rec_w_ispkt,
   output logic                               rec_w_busy,
   output logic [axil_pkg::W_REC_W-1:0]       rec_w_data,
   output logic                               rec_ar_ispkt,
   output logic                               rec_ar_busy,
   output logic [axil_pkg::AR_REC_W-1:0]      rec_ar_data
);

   logic                          aw_new;
   logic                          w_new;
   logic                          ar_new;
   logic                          fifo_pop;
   logic                          aw_fvalid;
   logic                          w_fvalid;
   logic                          ar_fvalid;
   logic                          aw_ispkt;
   logic                          aw_busy;
   logic [axil_pkg::AW_REC_W-1:0] aw_data;
   logic                          w_ispkt;
   logic                          w_busy;
   logic [axil_pkg::W_REC_W-1:0]  w_data;
   logic                          ar_ispkt;
   logic                          ar_busy;
   logic [axil_pkg::AR_REC_W-1:0] ar_data;

   //////////////////////////////////////////////////
   // payload and response pass-through
   //////////////////////////////////////////////////

   assign cl_awaddr = sh_awaddr;
   assign cl_wdata  = sh_wdata;
   assign cl_wstrb  = sh_wstrb;
   assign cl_araddr = sh_araddr;

   // b and r are not recorded
   assign sh_bresp  = cl_bresp;
   assign sh_bvalid = cl_bvalid;
   assign cl_bready = sh_bready;
   assign sh_rdata  = cl_rdata;
   assign sh_rresp  = cl_rresp;
   assign sh_rvalid = cl_rvalid;
   assign cl_rready = sh_rready;

   //////////////////////////////////////////////////
   // per channel recorders
   //////////////////////////////////////////////////

   // bubble on a channel whenever another one starts a packet
   channel_siderec #(.DEPTH(DEPTH), .WIDTH(axil_pkg::AW_REC_W)) u_aw_rec (
      .clk (clk), .sync_rst_n (sync_rst_n),
      .din (sh_awaddr), .sh_valid (sh_awvalid), .cl_ready (cl_awready),
      .bubble_en (w_new || ar_new), .rec_ready (fifo_pop),
      .sh_ready (sh_awready), .cl_valid (cl_awvalid), .new_packet (aw_new),
      .ispkt_out (aw_ispkt), .busy_out (aw_busy), .dout (aw_data),
      .rec_valid (aw_fvalid)
   );

   channel_siderec #(.DEPTH(DEPTH), .WIDTH(axil_pkg::W_REC_W)) u_w_rec (
      .clk (clk), .sync_rst_n (sync_rst_n),
      .din ({sh_wdata, sh_wstrb}), .sh_valid (sh_wvalid), .cl_ready (cl_wready),
      .bubble_en (aw_new || ar_new), .rec_ready (fifo_pop),
      .sh_ready (sh_wready), .cl_valid (cl_wvalid), .new_packet (w_new),
      .ispkt_out (w_ispkt), .busy_out (w_busy), .dout (w_data),
      .rec_valid (w_fvalid)
   );

   channel_siderec #(.DEPTH(DEPTH), .WIDTH(axil_pkg::AR_REC_W)) u_ar_rec (
      .clk (clk), .sync_rst_n (sync_rst_n),
      .din (sh_araddr), .sh_valid (sh_arvalid), .cl_ready (cl_arready),
      .bubble_en (aw_new || w_new), .rec_ready (fifo_pop),
      .sh_ready (sh_arready), .cl_valid (cl_arvalid), .new_packet (ar_new),
      .ispkt_out (ar_ispkt), .busy_out (ar_busy), .dout (ar_data),
      .rec_valid (ar_fvalid)
   );

   // merge into one sequenced record
   rec_merge #(
      .AW_W (axil_pkg::AW_REC_W),
      .W_W  (axil_pkg::W_REC_W),
      .AR_W (axil_pkg::AR_REC_W)
   ) u_merge (
      .clk (clk), .sync_rst_n (sync_rst_n),
      .aw_valid (aw_fvalid), .w_valid (w_fvalid), .ar_valid (ar_fvalid),
      .aw_ispkt (aw_ispkt), .aw_busy (aw_busy), .aw_data (aw_data),
      .w_ispkt (w_ispkt), .w_busy (w_busy), .w_data (w_data),
      .ar_ispkt (ar_ispkt), .ar_busy (ar_busy), .ar_data (ar_data),
      .rec_ready (rec_ready), .fifo_pop (fifo_pop),
      .rec_valid (rec_valid), .rec_seq (rec_seq),
      .rec_aw_ispkt (rec_aw_ispkt), .rec_aw_busy (rec_aw_busy), .rec_aw_data (rec_aw_data),
      .rec_w_ispkt (rec_w_ispkt), .rec_w_busy (rec_w_busy), .rec_w_data (rec_w_data),
      .rec_ar_ispkt (rec_ar_ispkt), .rec_ar_busy (rec_ar_busy), .rec_ar_data (rec_ar_data)
   );

endmodule

// File: src/rec_merge.sv
`timescale 1ns/1ns

module rec_merge #(
   parameter int AW_W = axil_pkg::AW_REC_W,
   parameter int W_W  = axil_pkg::W_REC_W,
   parameter int AR_W = axil_pkg::AR_REC_W
) (
   input  logic                       clk,
   input  logic                       sync_rst_n,
   input  logic                       aw_valid,
   input  logic                       w_valid,
   input  logic                       ar_valid,
   input  logic                       aw_ispkt,
   input  logic                       aw_busy,
   input  logic [AW_W-1:0]            aw_data,
   input  logic                       w_ispkt,
   input  logic                       w_busy,
   input  logic [W_W-1:0]             w_data,
   input  logic                       ar_ispkt,
   input  logic                       ar_busy,
   input  logic [AR_W-1:0]            ar_data,
   input  logic                       rec_ready,
   output logic                       fifo_pop,
   output logic                       rec_valid,
   output logic [rec_pkg::SEQ_W-1:0]  rec_seq,
   output logic                       rec_aw_ispkt,
   output logic                       rec_aw_busy,
   output logic [AW_W-1:0]            rec_aw_data,
   output logic                       rec_w_ispkt,
   output logic                       rec_w_busy,
   output logic [W_W-1:0]             rec_w_data,
   output logic                       rec_ar_ispkt,
   output logic                       rec_ar_busy,
   output logic [AR_W-1:0]            rec_ar_data
);

   logic                      all_valid;
   logic [rec_pkg::SEQ_W-1:0] next_seq;

   // fifos move together, so all heads are present or none
   assign all_valid = aw_valid && w_valid && ar_valid;
   // load when the output slot is free or draining this cycle
   assign fifo_pop  = all_valid && (!rec_valid || rec_ready);

   //////////////////////////////////////////////////
   // output slot control and sequence
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         rec_valid <= 1'b0;
         rec_seq   <= '0;
         next_seq  <= '0;
      end else if (fifo_pop) begin
         rec_valid <= 1'b1;
         rec_seq   <= next_seq;
         // wraps at 2**SEQ_W
         next_seq  <= next_seq + rec_pkg::SEQ_W'(1);
      end else if (rec_ready) begin
         rec_valid <= 1'b0;
      end
   end

   // record payload
   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         rec_aw_ispkt <= aw_ispkt;
         rec_aw_busy  <= aw_busy;
         rec_aw_data  <= aw_data;
         rec_w_ispkt  <= w_ispkt;
         rec_w_busy   <= w_busy;
         rec_w_data   <= w_data;
         rec_ar_ispkt <= ar_ispkt;
         rec_ar_busy  <= ar_busy;
         rec_ar_data  <= ar_data;
      end
   end

   // lockstep push in the recorders keeps the counts equal
   a_lockstep: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (aw_valid == w_valid) && (w_valid == ar_valid))
      else $error("rec_merge: channel fifos out of step");

   // a row of bubbles only is never pushed
   a_has_pkt: assert property (@(posedge clk) disable iff (!sync_rst_n)
      fifo_pop |-> (aw_ispkt || w_ispkt || ar_ispkt))
      else $error("rec_merge: popped entry without a packet");

endmodule

// File: src/channel_siderec.sv
`timescale 1ns/1ns

module channel_siderec #(
   parameter int DEPTH = 8,
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             sync_rst_n,
   input  logic [WIDTH-1:0] din,
   input  logic             sh_valid,
   input  logic             cl_ready,
   input  logic             bubble_en,
   input  logic             rec_ready,
   output logic             sh_ready,
   output logic             cl_valid,
   output logic             new_packet,
   output logic             ispkt_out,
   output logic             busy_out,
   output logic [WIDTH-1:0] dout,
   output logic             rec_valid
);

   localparam int ENTRY_W = WIDTH + rec_pkg::REC_FLAG_W;

   logic               busy;
   logic               past_busy;
   logic               full;
   logic               push;
   logic               pop;
   logic [ENTRY_W-1:0] push_entry;
   logic [ENTRY_W-1:0] pop_entry;

   //////////////////////////////////////////////////
   // packet detect
   //////////////////////////////////////////////////

   // request pending but not taken this cycle
   assign busy = sh_valid && !sh_ready;

   always_ff @(posedge clk) begin
      if (!sync_rst_n)
         past_busy <= 1'b0;
      else
         past_busy <= busy;
   end

   // first cycle of a transaction so a held valid counts once
   assign new_packet = sh_valid && !past_busy;

   //////////////////////////////////////////////////
   // record fifo
   //////////////////////////////////////////////////

   // bubble when another channel records
   // busy is the previous cycle's since completion shows one cycle after valid && ready
   assign push       = new_packet || bubble_en;
   assign push_entry = {new_packet, past_busy, din};
   assign pop        = rec_valid && rec_ready;

   flop_fifo #(
      .DEPTH (DEPTH),
      .WIDTH (ENTRY_W)
   ) u_fifo (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .push       (push),
      .push_data  (push_entry),
      .pop        (pop),
      .pop_data   (pop_entry),
      .watermark  (full),
      .data_valid (rec_valid)
   );

   assign {ispkt_out, busy_out, dout} = pop_entry;

   // hold off both sides while the fifo is near full
   assign sh_ready = cl_ready && !full;
   assign cl_valid = sh_valid && !full;

   // the shell holds a request until it is taken
   a_valid_held: assert property (@(posedge clk) disable iff (!sync_rst_n)
      past_busy |-> sh_valid)
      else $error("channel_siderec: shell valid dropped before handshake");

endmodule

// File: src/flop_fifo.sv
`timescale 1ns/1ns

module flop_fifo #(
   parameter int DEPTH = 8,
   parameter int WIDTH = 8
) (
   input  logic             clk,
   input  logic             sync_rst_n,
   input  logic             push,
   input  logic [WIDTH-1:0] push_data,
   input  logic             pop,
   output logic [WIDTH-1:0] pop_data,
   output logic             watermark,
   output logic             data_valid
);

   localparam int PTR_W = $clog2(DEPTH);
   // count needs to reach DEPTH itself
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // explicit wrap so depth need not be a power of two
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         case ({push, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
      end
   end

   // storage array
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   // head entry shows without a read cycle
   assign pop_data   = mem[rd_ptr];
   assign data_valid = (count != '0);
   // one slot of slack left when this rises
   assign watermark  = (count >= CNT_W'(DEPTH - 1));

   a_no_overflow: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (push && !pop) |-> (count != CNT_W'(DEPTH)))
      else $error("flop_fifo: push while full");

   a_no_underflow: assert property (@(posedge clk) disable iff (!sync_rst_n)
      pop |-> (count != '0))
      else $error("flop_fifo: pop while empty");

endmodule

// File: src/rec_pkg.sv
package rec_pkg;

   //////////////////////////////////////////////////
   // record stream
   //////////////////////////////////////////////////

   // flag bits stored with each fifo entry
   // msb is-packet, then busy of the previous cycle
   localparam int REC_FLAG_W = 2;

   // sequence stamp on the merged record, wraps naturally
   localparam int SEQ_W = 16;

endpackage

// File: src/axil_pkg.sv
package axil_pkg;

   //////////////////////////////////////////////////
   // axi-lite bus fields
   //////////////////////////////////////////////////

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   // one strobe bit per data byte
   localparam int STRB_W = DATA_W / 8;
   localparam int RESP_W = 2;

   //////////////////////////////////////////////////
   // recorded payload per request channel
   //////////////////////////////////////////////////

   localparam int AW_REC_W = ADDR_W;
   // write data packs as {wdata, wstrb}
   localparam int W_REC_W  = DATA_W + STRB_W;
   localparam int AR_REC_W = ADDR_W;

endpackage
